/* hdl/fifo_cfg_pkg.sv */
package fifo_cfg_pkg;

	// Word width on the write side
	localparam int W_DATA_W = 32;

	// Byte width on the read side
	localparam int R_DATA_W = 8;

	// Bytes per word
	// Write width is an exact multiple of the read width
	localparam int RATIO = W_DATA_W / R_DATA_W;

	// Storage addressed in bytes on the read side
	localparam int R_ADDR_W = 6;

	// One write row holds RATIO bytes, so the lane bits drop out
	localparam int W_ADDR_W = R_ADDR_W - $clog2(RATIO);

	// Capacity counted in read units
	localparam int FIFO_DEPTH = 2 ** R_ADDR_W;

	// Extra bit so a completely full FIFO still fits
	localparam int OCC_W = R_ADDR_W + 1;

	// Saturating count of words lost at the input
	localparam int DROP_W = 8;

endpackage

/* hdl/stream_pkg.sv */
package stream_pkg;

	// Input word with its write strobe
	typedef struct packed {
		logic [fifo_cfg_pkg::W_DATA_W-1:0] data;
		logic                              valid;
	} word_s;

	// Output byte
	// last is set on the byte that came from the top lane of a word
	typedef struct packed {
		logic [fifo_cfg_pkg::R_DATA_W-1:0] data;
		logic                              last;
		logic                              valid;
	} byte_s;

endpackage

/* hdl/asym_dual_port_mem.sv */
module asym_dual_port_mem (
	input  logic                              clk,
	input  logic                              w_en,
	input  logic [fifo_cfg_pkg::W_ADDR_W-1:0] w_addr,
	input  logic [fifo_cfg_pkg::W_DATA_W-1:0] data_in,
	input  logic                              r_en,
	input  logic [fifo_cfg_pkg::R_ADDR_W-1:0] r_addr,
	output logic [fifo_cfg_pkg::R_DATA_W-1:0] data_out
);

	// One row per word, lane 0 holds the low byte
	logic [fifo_cfg_pkg::RATIO-1:0][fifo_cfg_pkg::R_DATA_W-1:0] mem [2**fifo_cfg_pkg::W_ADDR_W];

	// Read address split into row and lane
	logic [fifo_cfg_pkg::W_ADDR_W-1:0]        r_row;
	logic [$clog2(fifo_cfg_pkg::RATIO)-1:0]   r_lane;

	assign r_row  = r_addr[fifo_cfg_pkg::R_ADDR_W-1 -: fifo_cfg_pkg::W_ADDR_W];
	assign r_lane = r_addr[$clog2(fifo_cfg_pkg::RATIO)-1:0];

	// Whole word goes in at once
	always_ff @(posedge clk) begin
		if (w_en) begin
			mem[w_addr] <= data_in;
		end
	end

	// Registered narrow read, holds its value between reads
	always_ff @(posedge clk) begin
		if (r_en) begin
			data_out <= mem[r_row][r_lane];
		end
	end

endmodule

/* hdl/asym_sync_fifo.sv */
module asym_sync_fifo (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              write_en,
	input  logic [fifo_cfg_pkg::W_DATA_W-1:0] data_in,
	output logic                              full,
	input  logic                              read_en,
	output logic [fifo_cfg_pkg::R_DATA_W-1:0] data_out,
	output logic                              empty
);

	// Occupancy in bytes
	logic [fifo_cfg_pkg::OCC_W-1:0]    occupancy;

	// Word pointer on the write side, byte pointer on the read side
	logic [fifo_cfg_pkg::W_ADDR_W-1:0] wptr;
	logic [fifo_cfg_pkg::R_ADDR_W-1:0] rptr;

	// Enables after masking
	logic                              write_en_int;
	logic                              read_en_int;

	assign write_en_int = write_en & ~full;
	assign read_en_int  = read_en & ~empty;

	// A write needs room for a whole word
	assign full  = occupancy >
		fifo_cfg_pkg::OCC_W'(fifo_cfg_pkg::FIFO_DEPTH - fifo_cfg_pkg::RATIO);
	assign empty = (occupancy == '0);

	// Up by a word, down by a byte
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			occupancy <= '0;
		end else begin
			case ({write_en_int, read_en_int})
				2'b10: occupancy <= occupancy + fifo_cfg_pkg::OCC_W'(fifo_cfg_pkg::RATIO);
				2'b01: occupancy <= occupancy - fifo_cfg_pkg::OCC_W'(1);
				2'b11: occupancy <= occupancy + fifo_cfg_pkg::OCC_W'(fifo_cfg_pkg::RATIO - 1);
				default: occupancy <= occupancy;
			endcase
		end
	end

	// Write pointer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wptr <= '0;
		end else if (write_en_int) begin
			wptr <= wptr + fifo_cfg_pkg::W_ADDR_W'(1);
		end
	end

	// Read pointer, wraps together with the write pointer every 16 words
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rptr <= '0;
		end else if (read_en_int) begin
			rptr <= rptr + fifo_cfg_pkg::R_ADDR_W'(1);
		end
	end

	asym_dual_port_mem u_mem (
		.clk      (clk),
		.w_en     (write_en_int),
		.w_addr   (wptr),
		.data_in  (data_in),
		.r_en     (read_en_int),
		.r_addr   (rptr),
		.data_out (data_out)
	);

	// Word-sized steps must never push the count past capacity
	a_occ_bound: assert property (@(posedge clk) disable iff (rst)
		occupancy <= fifo_cfg_pkg::OCC_W'(fifo_cfg_pkg::FIFO_DEPTH))
		else $error("FIFO occupancy above capacity");

	// Write pointer stays put while full
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		full |=> $stable(wptr))
		else $error("FIFO written while full");

	// Read pointer stays put while empty
	a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
		empty |=> $stable(rptr))
		else $error("FIFO read while empty");

endmodule

/* hdl/word_ingress.sv */
module word_ingress (
	input  logic                              clk,
	input  logic                              rst,
	input  stream_pkg::word_s                 in_word,
	input  logic                              full,
	output logic                              write_en,
	output logic [fifo_cfg_pkg::W_DATA_W-1:0] data_in,
	output logic [fifo_cfg_pkg::DROP_W-1:0]   drop_count
);

	// Strobe that finds no room
	logic drop;

	// Words go straight through when there is space
	assign write_en = in_word.valid & ~full;
	assign data_in  = in_word.data;

	// No stall towards the source, the word is lost
	assign drop = in_word.valid & full;

	// Saturates at all ones
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			drop_count <= '0;
		end else if (drop && drop_count != '1) begin
			drop_count <= drop_count + fifo_cfg_pkg::DROP_W'(1);
		end
	end

endmodule

/* hdl/byte_egress.sv */
module byte_egress (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              pull,
	input  logic                              empty,
	input  logic [fifo_cfg_pkg::R_DATA_W-1:0] fifo_data,
	output logic                              read_en,
	output stream_pkg::byte_s                 out_byte
);

	// Read taken by the FIFO this cycle
	logic                                   accepted;

	// Delayed to line up with the registered memory output
	logic                                   accepted_q;
	logic                                   last_q;

	// Lane of the next byte to be read
	logic [$clog2(fifo_cfg_pkg::RATIO)-1:0] lane;

	// FIFO masks the request with empty
	assign read_en = pull;

	// Same condition the FIFO uses internally
	assign accepted = pull & ~empty;

	// Stays aligned with the low bits of the read pointer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane <= '0;
		end else if (accepted) begin
			lane <= lane + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			accepted_q <= 1'b0;
			last_q     <= 1'b0;
		end else begin
			accepted_q <= accepted;
			if (accepted) begin
				// Top lane closes the word
				last_q <= (int'(lane) == fifo_cfg_pkg::RATIO - 1);
			end
		end
	end

	assign out_byte.data  = fifo_data;
	assign out_byte.last  = last_q;
	assign out_byte.valid = accepted_q;

	// Memory output only moves on a read that this side counted, so a new byte always has valid
	a_hold_without_read: assert property (@(posedge clk) disable iff (rst)
		!out_byte.valid |-> $stable(out_byte.data))
		else $error("Byte data changed without an accepted read");

endmodule

/* hdl/width_conv_top.sv */
module width_conv_top (
	input  logic                            clk,
	input  logic                            rst,
	input  stream_pkg::word_s               in_word,
	input  logic                            pull,
	output stream_pkg::byte_s               out_byte,
	output logic [fifo_cfg_pkg::DROP_W-1:0] drop_count
);

	// Ingress to FIFO
	logic                              write_en;
	logic [fifo_cfg_pkg::W_DATA_W-1:0] data_in;
	logic                              full;

	// FIFO to egress
	logic                              read_en;
	logic [fifo_cfg_pkg::R_DATA_W-1:0] fifo_data;
	logic                              empty;

	word_ingress u_ingress (
		.clk        (clk),
		.rst        (rst),
		.in_word    (in_word),
		.full       (full),
		.write_en   (write_en),
		.data_in    (data_in),
		.drop_count (drop_count)
	);

	asym_sync_fifo u_fifo (
		.clk      (clk),
		.rst      (rst),
		.write_en (write_en),
		.data_in  (data_in),
		.full     (full),
		.read_en  (read_en),
		.data_out (fifo_data),
		.empty    (empty)
	);

	byte_egress u_egress (
		.clk       (clk),
		.rst       (rst),
		.pull      (pull),
		.empty     (empty),
		.fifo_data (fifo_data),
		.read_en   (read_en),
		.out_byte  (out_byte)
	);

endmodule

/* tb/tb_checker.sv */
module tb_checker (
	input logic                            clk,
	input logic                            rst,
	input stream_pkg::byte_s               out_byte,
	input logic [fifo_cfg_pkg::DROP_W-1:0] drop_count,
	input logic                            end_check
);

	// Filled by tb_top, oldest byte first
	stream_pkg::byte_s               exp_q[$];
	logic [fifo_cfg_pkg::DROP_W-1:0] exp_drop = '0;
	int                              errors = 0;
	logic                            reset_seen = 1'b0;
	logic                            drop_seen = 1'b0;

	task automatic compare_byte();
		stream_pkg::byte_s want;
		if (exp_q.size() == 0) begin
			$display("Unexpected byte 0x%h came out with nothing left to expect", out_byte.data);
			errors++;
			return;
		end
		want = exp_q.pop_front();
		if (out_byte.data !== want.data) begin
			$display("Error: out_byte.data is 0x%h, expected 0x%h", out_byte.data, want.data);
			errors++;
		end
		if (out_byte.last !== want.last) begin
			$display("Error: out_byte.last is 0x%h, expected 0x%h", out_byte.last, want.last);
			errors++;
		end
	endtask

	// Mid cycle, away from the edge where DUT registers change
	always @(negedge clk) begin
		if (!rst && !reset_seen) begin
			reset_seen = 1'b1;
			if (out_byte.valid !== 1'b0) begin
				$display("Error: out_byte.valid is 0x%h after reset, expected 0x0", out_byte.valid);
				errors++;
			end
			if (drop_count !== '0) begin
				$display("Error: drop_count is 0x%h after reset, expected 0x00", drop_count);
				errors++;
			end
		end
		if (!rst && out_byte.valid) begin
			compare_byte();
		end
		if (end_check && !drop_seen) begin
			drop_seen = 1'b1;
			if (drop_count !== exp_drop) begin
				$display("Error: drop_count is 0x%h, expected 0x%h", drop_count, exp_drop);
				errors++;
			end
		end
	end

endmodule

/* tb/tb_top.sv */
module tb_top;

	logic                            clk;
	logic                            rst;
	stream_pkg::word_s               in_word;
	logic                            pull;
	stream_pkg::byte_s               out_byte;
	logic [fifo_cfg_pkg::DROP_W-1:0] drop_count;
	logic                            end_check;

	// Level that pull goes back to after a P record
	logic                            pull_level;
	integer                          seed;
	int                              timeouts;
	int                              file_errors;

	width_conv_top DUT (
		.clk        (clk),
		.rst        (rst),
		.in_word    (in_word),
		.pull       (pull),
		.out_byte   (out_byte),
		.drop_count (drop_count)
	);

	tb_checker chk (
		.clk        (clk),
		.rst        (rst),
		.out_byte   (out_byte),
		.drop_count (drop_count),
		.end_check  (end_check)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Inputs move 1 after the rising edge
	task automatic hold_pull(input logic level, input int count);
		pull = level;
		repeat (count) begin
			@(posedge clk);
			#1;
		end
		pull = pull_level;
	endtask

	task automatic write_word(input logic [fifo_cfg_pkg::W_DATA_W-1:0] word);
		in_word = '{data: word, valid: 1'b1};
		hold_pull(pull_level, 1);
		in_word.valid = 1'b0;
	endtask

	task automatic expect_byte(input logic [fifo_cfg_pkg::R_DATA_W-1:0] data, input logic last);
		stream_pkg::byte_s b;
		b = '{data: data, last: last, valid: 1'b1};
		chk.exp_q.push_back(b);
	endtask

	// Low byte leaves first and the top byte closes the word
	task automatic expect_word(input logic [fifo_cfg_pkg::W_DATA_W-1:0] word);
		for (int i = 0; i < fifo_cfg_pkg::RATIO; i++) begin
			expect_byte(word[i*fifo_cfg_pkg::R_DATA_W +: fifo_cfg_pkg::R_DATA_W],
				i == fifo_cfg_pkg::RATIO - 1);
		end
	endtask

	task automatic random_words(input int count);
		logic [fifo_cfg_pkg::W_DATA_W-1:0] word;
		repeat (count) begin
			word = $random(seed);
			expect_word(word);
			write_word(word);
		end
	endtask

	task automatic run_file();
		int           fd;
		int           code;
		logic [63:0]  cmd;
		logic [31:0]  arg;
		logic [31:0]  last;
		logic [799:0] rest;
		fd = $fopen("tb/width_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file tb/width_tests.txt");
			file_errors++;
			return;
		end
		while ($fscanf(fd, " %s", cmd) == 1) begin
			if (cmd == "#") begin
				code = $fgets(rest, fd);
			end else if (cmd == "E") begin
				code = $fscanf(fd, " %h %h", arg, last) - 1;
				expect_byte(arg[fifo_cfg_pkg::R_DATA_W-1:0], last[0]);
			end else begin
				code = $fscanf(fd, " %h", arg);
				case (cmd)
					"W": write_word(arg);
					"P": hold_pull(1'b1, arg);
					"I": hold_pull(pull_level, arg);
					"L": begin
						pull_level = arg[0];
						pull       = arg[0];
					end
					"R": random_words(arg);
					"D": chk.exp_drop = arg[fifo_cfg_pkg::DROP_W-1:0];
					default: code = 0;
				endcase
			end
			if (code < 1) begin
				$display("Bad record %s in the test file", cmd);
				file_errors++;
			end
		end
		$fclose(fd);
	endtask

	// Anything still queued has to come out within a bounded number of cycles
	task automatic wait_drain();
		int n;
		n = 0;
		while (chk.exp_q.size() != 0 && n < 200) begin
			hold_pull(pull_level, 1);
			n++;
		end
		if (chk.exp_q.size() != 0) begin
			$display("Timeout: %0d expected bytes never came out", chk.exp_q.size());
			timeouts++;
		end
	endtask

	initial begin
		seed        = 32'h6208_a9f8;
		timeouts    = 0;
		file_errors = 0;
		rst         = 1'b1;
		in_word     = '0;
		pull        = 1'b0;
		pull_level  = 1'b0;
		end_check   = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		run_file();
		wait_drain();
		end_check = 1'b1;
		hold_pull(pull_level, 2);
		$display("Check errors: %0d, timeouts: %0d", chk.errors + file_errors, timeouts);
		if (chk.errors + file_errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* tb/width_tests.txt */
# Records are a letter followed by hex values
# W word  E byte last  P pull cycles  I idle cycles  L pull level  R random words  D drops
# Pull on an empty FIFO gives no byte
P 4 I 2
# Byte order
E 00 0 E 01 0 E 02 0 E 03 1
E d8 0 E c7 0 E b6 0 E a5 1
W 03020100 W a5b6c7d8
P 10 I 2
# Pull in short bursts
E 44 0 E 33 0 E 22 0 E 11 1
E 88 0 E 77 0 E 66 0 E 55 1
E cc 0 E bb 0 E aa 0 E 99 1
W 11223344 W 55667788 W 99aabbcc
P 2 I 3 P 1 I 1 P 3 I 2 P 5 I 1 P 4 I 2
# Writes while pull stays high
E fe 0 E ca 0 E ad 0 E 0b 1
E 78 0 E 56 0 E 34 0 E 12 1
E 0d 0 E f0 0 E fe 0 E ca 1
E 04 0 E 03 0 E 02 0 E 01 1
L 1
W 0badcafe I 1 W 12345678 I 2 W cafef00d W 01020304
I 0e
L 0 I 2
# Sixteen random words fill the FIFO and three more are dropped
R 10
W deadbeef W 0000ffff W 12121212
P 50
D 3

/* compile.f */
hdl/fifo_cfg_pkg.sv
hdl/stream_pkg.sv
hdl/asym_dual_port_mem.sv
hdl/asym_sync_fifo.sv
hdl/word_ingress.sv
hdl/byte_egress.sv
hdl/width_conv_top.sv
tb/tb_checker.sv
tb/tb_top.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_top
FILELIST   := compile.f
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
